// ==== source/rsa_pkg.sv ====
package rsa_pkg;

    localparam int RSA_WIDTH = 256;
    localparam int RSA_WORDS = 8;  // bus words per operand.

    typedef logic [RSA_WIDTH-1:0] rsa_word_t;
    typedef logic [RSA_WIDTH:0]   rsa_acc_t;
    typedef logic [31:0]          rsa_bus_t;
    typedef logic [8:0]           rsa_bit_idx_t;

    // byte addresses, operand blocks least significant word first.
    localparam logic [7:0] REG_CTRL      = 8'h00;  // bit 0 start.
    localparam logic [7:0] REG_STATUS    = 8'h04;  // bit 0 busy, bit 1 done.
    localparam logic [7:0] REG_N_BASE    = 8'h40;
    localparam logic [7:0] REG_BASE_BASE = 8'h60;
    localparam logic [7:0] REG_EXP_BASE  = 8'h80;
    localparam logic [7:0] REG_RES_BASE  = 8'hA0;

    typedef enum logic [2:0] {
        MONT_IDLE,
        MONT_ADD_B,
        MONT_ADD_N,
        MONT_SHIFT,
        MONT_REDUCE
    } mont_state_e;

    typedef enum logic [2:0] {
        EXP_IDLE,
        EXP_PREP,
        EXP_STEP,
        EXP_COLLECT,
        EXP_DONE
    } exp_state_e;

endpackage

// ==== source/rsa_mont_mul.sv ====
`timescale 1ns/1ps

module rsa_mont_mul (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_start,
    input  rsa_pkg::rsa_word_t i_n,
    input  rsa_pkg::rsa_word_t i_a,
    input  rsa_pkg::rsa_word_t i_b,
    output rsa_pkg::rsa_word_t o_result,
    output logic               o_valid
);
    import rsa_pkg::*;

    mont_state_e  state_q;
    rsa_bit_idx_t idx_q;
    rsa_acc_t     acc_q;
    logic         carry_q;  // bit 257, sum before shift can reach 2(N+b).
    logic         fin_q;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q <= MONT_IDLE;
            idx_q   <= '0;
            fin_q   <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            fin_q   <= 1'b0;
            o_valid <= fin_q;
            case (state_q)
                MONT_IDLE: begin
                    if (i_start) begin
                        idx_q   <= '0;
                        state_q <= MONT_ADD_B;
                    end
                end
                MONT_ADD_B: state_q <= MONT_ADD_N;
                MONT_ADD_N: state_q <= MONT_SHIFT;
                MONT_SHIFT: begin
                    if (idx_q == rsa_bit_idx_t'(RSA_WIDTH - 1)) begin
                        state_q <= MONT_REDUCE;
                    end else begin
                        idx_q   <= idx_q + 1'b1;
                        state_q <= MONT_ADD_B;
                    end
                end
                MONT_REDUCE: begin
                    fin_q   <= 1'b1;
                    state_q <= MONT_IDLE;
                end
                default: state_q <= MONT_IDLE;
            endcase
        end
    end

    // accumulator stays below N + b after every shift.
    always_ff @(posedge i_clk) begin
        case (state_q)
            MONT_IDLE: begin
                if (i_start) begin
                    acc_q   <= '0;
                    carry_q <= 1'b0;
                end
            end
            MONT_ADD_B: begin
                if (i_a[idx_q[7:0]]) begin
                    {carry_q, acc_q} <= {carry_q, acc_q} + {2'b00, i_b};
                end
            end
            MONT_ADD_N: begin
                if (acc_q[0]) begin
                    {carry_q, acc_q} <= {carry_q, acc_q} + {2'b00, i_n};
                end
            end
            MONT_SHIFT: {carry_q, acc_q} <= {1'b0, carry_q, acc_q[RSA_WIDTH:1]};
            MONT_REDUCE: begin
                if (acc_q >= {1'b0, i_n}) begin
                    acc_q <= acc_q - {1'b0, i_n};  // single correction suffices.
                end
            end
            default: ;
        endcase
        if (fin_q) begin
            o_result <= acc_q[RSA_WIDTH-1:0];
        end
    end

    a_result_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
        o_valid |-> (o_result < i_n));

endmodule

// ==== source/rsa_mont_prep.sv ====
`timescale 1ns/1ps

module rsa_mont_prep (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_start,
    input  rsa_pkg::rsa_word_t i_n,
    input  rsa_pkg::rsa_word_t i_a,
    output rsa_pkg::rsa_word_t o_result,
    output logic               o_valid
);
    import rsa_pkg::*;

    rsa_acc_t     v_q;
    rsa_acc_t     dbl;
    rsa_acc_t     red;
    rsa_bit_idx_t idx_q;  // 0 loads, 1..256 double.
    logic         busy_q;
    logic         fin_q;

    assign dbl = {v_q[RSA_WIDTH-1:0], 1'b0};  // v below N, top bit free.
    assign red = (dbl >= {1'b0, i_n}) ? dbl - {1'b0, i_n} : dbl;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            busy_q  <= 1'b0;
            idx_q   <= '0;
            fin_q   <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            fin_q   <= 1'b0;
            o_valid <= fin_q;
            if (!busy_q) begin
                if (i_start) begin
                    busy_q <= 1'b1;
                    idx_q  <= '0;
                end
            end else begin
                idx_q <= idx_q + 1'b1;
                if (idx_q == rsa_bit_idx_t'(RSA_WIDTH)) begin
                    busy_q <= 1'b0;
                    fin_q  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (busy_q) begin
            v_q <= (idx_q == '0) ? {1'b0, i_a} : red;
        end
        if (fin_q) begin
            o_result <= v_q[RSA_WIDTH-1:0];
        end
    end

    a_stays_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
        (busy_q && idx_q != '0) |=> (v_q < {1'b0, i_n}));

endmodule

// ==== source/rsa_exp_ctrl.sv ====
`timescale 1ns/1ps

module rsa_exp_ctrl (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_start,
    input  rsa_pkg::rsa_word_t i_n,
    input  rsa_pkg::rsa_word_t i_base,
    input  rsa_pkg::rsa_word_t i_exp,
    output rsa_pkg::rsa_word_t o_result,
    output logic               o_busy,
    output logic               o_done
);
    import rsa_pkg::*;

    exp_state_e   state_q;
    rsa_bit_idx_t idx_q;
    logic         prep_start_q;
    logic         mul_start_q;  // shared by both multipliers.
    logic         sq_seen_q;
    logic         mul_seen_q;
    logic         prep_valid;
    logic         sq_valid;
    logic         mul_valid;
    logic         sq_ready;
    logic         mul_ready;
    logic         last_bit;
    rsa_word_t    t_q;  // base^(2^i) in Montgomery form.
    rsa_word_t    m_q;  // running product, plain form.
    rsa_word_t    prep_result;
    rsa_word_t    sq_result;
    rsa_word_t    mul_result;

    rsa_mont_prep prep_i (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (prep_start_q),
        .i_n      (i_n),
        .i_a      (i_base),
        .o_result (prep_result),
        .o_valid  (prep_valid)
    );

    rsa_mont_mul sq_i (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (mul_start_q),
        .i_n      (i_n),
        .i_a      (t_q),
        .i_b      (t_q),
        .o_result (sq_result),
        .o_valid  (sq_valid)
    );

    rsa_mont_mul mul_i (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (mul_start_q),
        .i_n      (i_n),
        .i_a      (m_q),
        .i_b      (t_q),
        .o_result (mul_result),
        .o_valid  (mul_valid)
    );

    assign sq_ready  = sq_seen_q | sq_valid;
    assign mul_ready = mul_seen_q | mul_valid;
    assign last_bit  = (idx_q == rsa_bit_idx_t'(RSA_WIDTH - 1));
    assign o_result  = m_q;
    assign o_busy    = (state_q != EXP_IDLE);
    assign o_done    = (state_q == EXP_DONE);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q      <= EXP_IDLE;
            idx_q        <= '0;
            prep_start_q <= 1'b0;
            mul_start_q  <= 1'b0;
            sq_seen_q    <= 1'b0;
            mul_seen_q   <= 1'b0;
        end else begin
            prep_start_q <= 1'b0;
            mul_start_q  <= 1'b0;
            case (state_q)
                EXP_IDLE: begin
                    if (i_start) begin
                        prep_start_q <= 1'b1;
                        state_q      <= EXP_PREP;
                    end
                end
                EXP_PREP: begin
                    if (prep_valid) begin
                        idx_q       <= '0;
                        mul_start_q <= 1'b1;
                        state_q     <= EXP_STEP;
                    end
                end
                EXP_STEP: begin
                    if (sq_ready && mul_ready) begin
                        sq_seen_q  <= 1'b0;
                        mul_seen_q <= 1'b0;
                        state_q    <= EXP_COLLECT;
                    end else begin
                        sq_seen_q  <= sq_ready;
                        mul_seen_q <= mul_ready;
                    end
                end
                EXP_COLLECT: begin
                    if (last_bit) begin
                        state_q <= EXP_DONE;
                    end else begin
                        idx_q       <= idx_q + 1'b1;
                        mul_start_q <= 1'b1;
                        state_q     <= EXP_STEP;
                    end
                end
                EXP_DONE: state_q <= EXP_IDLE;
                default: state_q <= EXP_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == EXP_PREP && prep_valid) begin
            t_q <= prep_result;
            m_q <= rsa_word_t'(1);  // plain 1 keeps m out of the Montgomery domain.
        end else if (state_q == EXP_COLLECT) begin
            t_q <= sq_result;
            if (i_exp[idx_q[7:0]]) begin
                m_q <= mul_result;
            end
        end
    end

    // multiplier results only come back while stepping.
    a_valid_in_step: assert property (@(posedge i_clk) disable iff (i_rst)
        (sq_valid || mul_valid) |-> (state_q == EXP_STEP));

endmodule

// ==== source/rsa_wb_regs.sv ====
`timescale 1ns/1ps

module rsa_wb_regs (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_wb_cyc,
    input  logic               i_wb_stb,
    input  logic               i_wb_we,
    input  logic [7:0]         i_wb_adr,
    input  rsa_pkg::rsa_bus_t  i_wb_dat,
    output rsa_pkg::rsa_bus_t  o_wb_dat,
    output logic               o_wb_ack,
    output logic               o_start,
    output rsa_pkg::rsa_word_t o_n,
    output rsa_pkg::rsa_word_t o_base,
    output rsa_pkg::rsa_word_t o_exp,
    input  rsa_pkg::rsa_word_t i_result,
    input  logic               i_busy,
    input  logic               i_done
);
    import rsa_pkg::*;

    logic                         req;
    logic                         wr;
    logic                         busy;
    logic                         aligned;
    logic                         done_q;
    logic [2:0]                   blk;
    logic [$clog2(RSA_WORDS)-1:0] word_idx;
    logic [7:0]                   bit_ofs;
    rsa_bus_t                     rd_data;
    rsa_word_t                    n_q;
    rsa_word_t                    base_q;
    rsa_word_t                    exp_q;
    rsa_word_t                    res_q;

    assign req      = i_wb_cyc & i_wb_stb & ~o_wb_ack;  // one ack per request.
    assign wr       = req & i_wb_we;
    assign busy     = i_busy | o_start;  // start still in flight counts.
    assign aligned  = (i_wb_adr[1:0] == 2'b00);
    assign blk      = i_wb_adr[7:5];
    assign word_idx = i_wb_adr[4:2];
    assign bit_ofs  = {word_idx, 5'd0};

    assign o_n    = n_q;
    assign o_base = base_q;
    assign o_exp  = exp_q;

    always_comb begin
        rd_data = '0;
        if (aligned) begin
            if (i_wb_adr == REG_STATUS) begin
                rd_data = rsa_bus_t'({done_q, busy});
            end else if (blk == REG_N_BASE[7:5]) begin
                rd_data = n_q[bit_ofs +: $bits(rsa_bus_t)];
            end else if (blk == REG_BASE_BASE[7:5]) begin
                rd_data = base_q[bit_ofs +: $bits(rsa_bus_t)];
            end else if (blk == REG_EXP_BASE[7:5]) begin
                rd_data = exp_q[bit_ofs +: $bits(rsa_bus_t)];
            end else if (blk == REG_RES_BASE[7:5]) begin
                rd_data = res_q[bit_ofs +: $bits(rsa_bus_t)];
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_wb_ack <= 1'b0;
            o_start  <= 1'b0;
            done_q   <= 1'b0;
            res_q    <= '0;
        end else begin
            o_wb_ack <= req;
            o_start  <= wr && (i_wb_adr == REG_CTRL) && i_wb_dat[0] && !busy;
            if (o_start) begin
                done_q <= 1'b0;
            end else if (i_done) begin
                done_q <= 1'b1;  // sticky until next run.
            end
            if (i_done) begin
                res_q <= i_result;
            end
        end
    end

    // operands frozen while a run is in progress.
    always_ff @(posedge i_clk) begin
        if (req) begin
            o_wb_dat <= rd_data;
        end
        if (wr && aligned && !busy) begin
            if (blk == REG_N_BASE[7:5]) begin
                n_q[bit_ofs +: $bits(rsa_bus_t)] <= i_wb_dat;
            end else if (blk == REG_BASE_BASE[7:5]) begin
                base_q[bit_ofs +: $bits(rsa_bus_t)] <= i_wb_dat;
            end else if (blk == REG_EXP_BASE[7:5]) begin
                exp_q[bit_ofs +: $bits(rsa_bus_t)] <= i_wb_dat;
            end
        end
    end

    // an issued start is always taken by the sequencer.
    a_start_taken: assert property (@(posedge i_clk) disable iff (i_rst)
        o_start |=> i_busy);

endmodule

// ==== source/rsa_core_top.sv ====
`timescale 1ns/1ps

module rsa_core_top (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_wb_cyc,
    input  logic              i_wb_stb,
    input  logic              i_wb_we,
    input  logic [7:0]        i_wb_adr,
    input  rsa_pkg::rsa_bus_t i_wb_dat,
    output rsa_pkg::rsa_bus_t o_wb_dat,
    output logic              o_wb_ack
);
    import rsa_pkg::*;

    logic      start;
    logic      busy;
    logic      done;
    rsa_word_t modulus;
    rsa_word_t base;
    rsa_word_t exponent;
    rsa_word_t result;

    rsa_wb_regs regs_i (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .o_start  (start),
        .o_n      (modulus),
        .o_base   (base),
        .o_exp    (exponent),
        .i_result (result),
        .i_busy   (busy),
        .i_done   (done)
    );

    rsa_exp_ctrl exp_i (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (start),
        .i_n      (modulus),
        .i_base   (base),
        .i_exp    (exponent),
        .o_result (result),
        .o_busy   (busy),
        .o_done   (done)
    );

endmodule

// ==== bench/rsa_tb_wb.svh ====
`ifndef RSA_TB_WB_SVH
`define RSA_TB_WB_SVH

localparam int ACK_TIMEOUT = 16;
localparam int DONE_POLLS  = 150000;  // each poll is at least two cycles.

// called right after the request is driven on a falling edge.
task automatic wait_ack(input logic [7:0] adr);
    int unsigned waited;
    waited = 0;
    do begin
        @(negedge clk);
        waited++;
    end while (!wb_ack && waited < ACK_TIMEOUT);
    assert (wb_ack) else begin
        fail_now($sformatf("no Wishbone ack for address %h", adr));
    end
endtask

task automatic bus_write(input logic [7:0] adr, input rsa_bus_t data);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    wait_ack(adr);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
endtask

task automatic bus_read(input logic [7:0] adr, output rsa_bus_t data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_ack(adr);
    data   = wb_dat_r;  // valid while ack is high.
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
endtask

task automatic write_operand(input logic [7:0] blk, input rsa_word_t value);
    for (int i = 0; i < RSA_WORDS; i++) begin
        bus_write(blk + 8'(4 * i), value[32*i +: 32]);
    end
endtask

task automatic read_operand(input logic [7:0] blk, output rsa_word_t value);
    rsa_bus_t word;
    value = '0;
    for (int i = 0; i < RSA_WORDS; i++) begin
        bus_read(blk + 8'(4 * i), word);
        value[32*i +: 32] = word;
    end
endtask

task automatic load_operands(input rsa_word_t n, input rsa_word_t b, input rsa_word_t e);
    write_operand(REG_N_BASE, n);
    write_operand(REG_BASE_BASE, b);
    write_operand(REG_EXP_BASE, e);
endtask

task automatic wait_done(input string name, output rsa_bus_t status);
    int unsigned polls;
    polls = 0;
    do begin
        bus_read(REG_STATUS, status);
        polls++;
    end while (!status[1] && polls < DONE_POLLS);
    assert (status[1]) else begin
        fail_now($sformatf("%s never reported done in STATUS", name));
    end
endtask

`endif

// ==== bench/rsa_tb.sv ====
`timescale 1ns/1ps

module rsa_tb;
    import rsa_pkg::*;

    localparam int DRAIN_TIMEOUT = 16;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [7:0]  wb_adr;
    rsa_bus_t    wb_dat_w;
    rsa_bus_t    wb_dat_r;
    logic        wb_ack;
    logic [31:0] lfsr_q;
    string       name_q[$];
    rsa_word_t   want_q[$];
    rsa_word_t   got_q[$];
    int unsigned pushed;
    int unsigned compared;
    string       cmp_name;
    rsa_word_t   cmp_want;
    rsa_word_t   cmp_got;

    rsa_core_top dut_i (
        .i_clk    (clk),
        .i_rst    (rst),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat_w),
        .o_wb_dat (wb_dat_r),
        .o_wb_ack (wb_ack)
    );

    always #50 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    `include "rsa_tb_wb.svh"

    // fibonacci form, taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic rsa_word_t rand_word();
        rsa_word_t w;
        for (int i = 0; i < RSA_WIDTH; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w[i]   = lfsr_q[0];  // one step per bit.
        end
        return w;
    endfunction

    function automatic rsa_word_t rand_modulus();
        rsa_word_t w;
        w = rand_word();
        w[RSA_WIDTH-1] = 1'b1;
        w[0] = 1'b1;
        return w;
    endfunction

    // square-and-multiply on double-width products.
    function automatic rsa_word_t ref_modexp(input rsa_word_t b, input rsa_word_t e,
                                             input rsa_word_t n);
        logic [2*RSA_WIDTH-1:0] m;
        logic [2*RSA_WIDTH-1:0] r;
        logic [2*RSA_WIDTH-1:0] t;
        m = {{RSA_WIDTH{1'b0}}, n};
        r = 1;
        t = {{RSA_WIDTH{1'b0}}, b} % m;
        for (int i = 0; i < RSA_WIDTH; i++) begin
            if (e[i]) begin
                r = (r * t) % m;
            end
            t = (t * t) % m;
        end
        return r[RSA_WIDTH-1:0];
    endfunction

    task automatic expect_word(input string name, input rsa_word_t want, input rsa_word_t got);
        name_q.push_back(name);
        want_q.push_back(want);
        got_q.push_back(got);
        pushed++;
    endtask

    task automatic check_bus(input string name, input rsa_bus_t want, input rsa_bus_t got);
        assert (got == want) else begin
            fail_now($sformatf("Fail %s expected %h actual %h", name, want, got));
        end
    endtask

    task automatic run_case(input string name, input rsa_word_t n, input rsa_word_t b,
                            input rsa_word_t e, input rsa_word_t want);
        rsa_bus_t  status;
        rsa_word_t got;
        load_operands(n, b, e);
        bus_write(REG_CTRL, 32'h1);
        wait_done(name, status);
        check_bus($sformatf("%s status", name), 32'h2, status);
        read_operand(REG_RES_BASE, got);
        expect_word(name, want, got);
    endtask

    // stimulus moves on falling edges, so compare on rising ones.
    always @(posedge clk) begin
        if (got_q.size() != 0) begin
            cmp_name = name_q.pop_front();
            cmp_want = want_q.pop_front();
            cmp_got  = got_q.pop_front();
            compared++;
            assert (cmp_got == cmp_want) else begin
                fail_now($sformatf("Fail %s expected %h actual %h", cmp_name, cmp_want,
                                   cmp_got));
            end
        end
    end

    initial begin
        rsa_word_t   n;
        rsa_word_t   b;
        rsa_word_t   e;
        rsa_word_t   got;
        rsa_bus_t    word;
        int unsigned waited;
        clk      = 1'b0;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        lfsr_q   = 32'hb8c38a71;
        pushed   = 0;
        compared = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        bus_read(REG_STATUS, word);
        check_bus("reset status", 32'h0, word);
        read_operand(REG_RES_BASE, got);
        expect_word("reset result", '0, got);
        n = rand_word();
        b = rand_word();
        e = rand_word();
        load_operands(n, b, e);
        read_operand(REG_N_BASE, got);
        expect_word("readback n", n, got);
        read_operand(REG_BASE_BASE, got);
        expect_word("readback base", b, got);
        read_operand(REG_EXP_BASE, got);
        expect_word("readback exp", e, got);
        bus_read(8'h20, word);
        check_bus("unmapped 0x20", 32'h0, word);
        bus_read(8'hE0, word);
        check_bus("unmapped 0xe0", 32'h0, word);

        n = rand_modulus();
        b = rand_word() % n;
        run_case("exp zero", n, b, '0, rsa_word_t'(1));
        run_case("exp one", n, b, rsa_word_t'(1), b);

        for (int k = 0; k < 3; k++) begin
            n = rand_modulus();
            b = rand_word() % n;
            e = rand_word();
            run_case($sformatf("random %0d", k), n, b, e, ref_modexp(b, e, n));
        end

        // start and base write while busy must both be dropped.
        n = rand_modulus();
        b = rand_word() % n;
        e = rand_word();
        load_operands(n, b, e);
        bus_write(REG_CTRL, 32'h1);
        bus_read(REG_STATUS, word);
        check_bus("busy status", 32'h1, word);
        bus_write(REG_CTRL, 32'h1);
        bus_write(REG_BASE_BASE, ~b[31:0]);
        read_operand(REG_BASE_BASE, got);
        expect_word("base held while busy", b, got);
        wait_done("busy run", word);
        check_bus("busy run status", 32'h2, word);
        read_operand(REG_RES_BASE, got);
        expect_word("busy run", ref_modexp(b, e, n), got);

        n = rand_modulus();
        run_case("max exponent", n, n - 1'b1, '1, n - 1'b1);  // (N-1)^odd is N-1.

        waited = 0;
        while (compared != pushed && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (compared == pushed) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("compare process did not check every result");
            $display("Simulation finished: FAIL");
            $fatal(1, "results left unchecked");
        end
    end

endmodule

// ==== rsa_core_top.f ====
source/rsa_pkg.sv
source/rsa_mont_mul.sv
source/rsa_mont_prep.sv
source/rsa_exp_ctrl.sv
source/rsa_wb_regs.sv
source/rsa_core_top.sv
+incdir+bench
bench/rsa_tb.sv

// ==== Makefile ====
TOP := rsa_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f rsa_core_top.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f rsa_core_top.f -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
